//--- common/rv32i_types.sv
package rv32i_types;

    // basic datapath widths shared by every stage of the back end

    localparam int XLEN = 32;                     // data and address word width
    localparam int REG_COUNT = 32;                // architectural integer registers
    localparam int BYTE_LANES = XLEN / 8;

    // data or address word
    typedef logic [XLEN-1:0] rv32i_word;

    // register index, x0..x31
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    // one bit per byte lane of a word
    typedef logic [BYTE_LANES-1:0] byte_en_t;

    // PC after reset, fetch starts here
    localparam rv32i_word RESET_PC = 32'h0000_0060;

endpackage : rv32i_types

//--- common/rv32i_ctrl.sv
package rv32i_ctrl;

    // value written back to the register file
    typedef enum logic [3:0] {
        alu_out,                                  // ALU result
        br_en,                                    // branch compare flag, zero extended
        u_imm,                                    // lui
        lw,                                       // full load word
        pc_plus4,                                 // jal / jalr link value
        lb,
        lbu,
        lh,
        lhu
    } regfilemux_sel_t;

    // data memory operation carried by the instruction
    typedef enum logic [2:0] {
        mem_none,
        load_b,
        load_h,
        load_w,
        store_b,
        store_h,
        store_w
    } mem_op_t;

    // next PC source
    // labels carry a prefix since the regfile mux already owns alu_out and pc_plus4
    typedef enum logic [1:0] {
        pcmux_pc_plus4,                           // sequential
        pcmux_alu_out,                            // taken branch / jal
        pcmux_alu_mod2                            // jalr, bit 0 cleared by fetch
    } pcmux_sel_t;

endpackage : rv32i_ctrl

//--- mem_stage/data_mem.sv
`timescale 1ns/10ps

module data_mem
#(
    parameter int DATA_MEM_WORDS = 256
)
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                read,
    input  logic [$clog2(DATA_MEM_WORDS)-1:0]   addr,
    input  rv32i_types::rv32i_word              wdata,
    input  rv32i_types::byte_en_t               wmask,
    output rv32i_types::rv32i_word              rdata
);

localparam int LANES = $bits(rv32i_types::byte_en_t);

rv32i_types::rv32i_word mem [DATA_MEM_WORDS];

// masked byte write
always_ff @(posedge clk)
begin
    for (int i = 0; i < LANES; i++)
    begin
        if (wmask[i])
            mem[addr][8*i +: 8] <= wdata[8*i +: 8];
    end
end

// registered read, data follows one edge after read
always_ff @(posedge clk)
begin
    if (read)
        rdata <= mem[addr];
end

// a single port RAM, the stage never issues both in one cycle
assert property (@(posedge clk) disable iff (!rst_n)
    !(read && (wmask != '0)))
    else $error("data_mem: read and write in the same cycle");

endmodule : data_mem

//--- mem_stage/mem_stage.sv
`timescale 1ns/10ps

module mem_stage
#(
    parameter int DATA_MEM_WORDS = 256
)
(
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            cmd_valid,
    input  rv32i_types::rv32i_word          cmd_alu,
    input  logic                            cmd_br_en,
    input  rv32i_types::rv32i_word          cmd_pc_plus4,
    input  rv32i_types::rv32i_word          cmd_u_imm,
    input  rv32i_types::rv32i_word          cmd_store_data,
    input  rv32i_types::reg_idx_t           cmd_rd,
    input  logic                            cmd_load_regfile,
    input  rv32i_ctrl::regfilemux_sel_t     cmd_regfilemux_sel,
    input  rv32i_ctrl::mem_op_t             cmd_mem_op,
    input  rv32i_ctrl::pcmux_sel_t          cmd_pcmux_sel,

    output logic                            wb_valid,
    output rv32i_types::rv32i_word          wb_alu,
    output logic                            wb_br_en,
    output rv32i_types::rv32i_word          wb_pc_plus4,
    output rv32i_types::rv32i_word          wb_u_imm,
    output rv32i_types::reg_idx_t           wb_rd,
    output logic                            wb_load_regfile,
    output rv32i_ctrl::regfilemux_sel_t     wb_regfilemux_sel,
    output rv32i_ctrl::pcmux_sel_t          wb_pcmux_sel,
    output rv32i_types::byte_en_t           wb_byte_en,
    output rv32i_types::rv32i_word          mem_rdata
);

localparam int ADDR_W = $clog2(DATA_MEM_WORDS);

logic                   is_load;
logic                   is_store;
logic                   is_half;
logic                   is_word;
rv32i_types::byte_en_t  byte_en;
rv32i_types::rv32i_word store_lanes;

// mem_op and the low address bits give the lanes touched
always_comb
begin
    is_load = 1'b0;
    is_store = 1'b0;
    is_half = 1'b0;
    is_word = 1'b0;
    byte_en = 4'b0000;
    case (cmd_mem_op)
        rv32i_ctrl::load_b, rv32i_ctrl::store_b:
        begin
            byte_en = 4'b0001 << cmd_alu[1:0];
        end
        rv32i_ctrl::load_h, rv32i_ctrl::store_h:
        begin
            is_half = 1'b1;
            byte_en = 4'b0011 << cmd_alu[1:0];
        end
        rv32i_ctrl::load_w, rv32i_ctrl::store_w:
        begin
            is_word = 1'b1;
            byte_en = 4'b1111;
        end
        default: byte_en = 4'b0000;           // mem_none
    endcase
    is_load = cmd_mem_op inside {rv32i_ctrl::load_b, rv32i_ctrl::load_h, rv32i_ctrl::load_w};
    is_store = cmd_mem_op inside {rv32i_ctrl::store_b, rv32i_ctrl::store_h,
                                  rv32i_ctrl::store_w};
end

assign store_lanes = cmd_store_data << {cmd_alu[1:0], 3'b000};   // move data up to its lane

data_mem #(
    .DATA_MEM_WORDS (DATA_MEM_WORDS)
) u_data_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .read  (cmd_valid && is_load),
    .addr  (cmd_alu[ADDR_W+1:2]),
    .wdata (store_lanes),
    .wmask ((cmd_valid && is_store) ? byte_en : 4'b0000),
    .rdata (mem_rdata)
);

// MEM/WB control
always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        wb_valid <= 1'b0;
        wb_load_regfile <= 1'b0;
        wb_regfilemux_sel <= rv32i_ctrl::alu_out;
        wb_pcmux_sel <= rv32i_ctrl::pcmux_pc_plus4;
        wb_pc_plus4 <= rv32i_types::RESET_PC + 32'd4;
    end
    else
    begin
        wb_valid <= cmd_valid;
        wb_load_regfile <= cmd_valid && cmd_load_regfile;
        if (cmd_valid)
        begin
            wb_regfilemux_sel <= cmd_regfilemux_sel;
            wb_pcmux_sel <= cmd_pcmux_sel;
            wb_pc_plus4 <= cmd_pc_plus4;
        end
    end
end

// MEM/WB payload
always_ff @(posedge clk)
begin
    if (cmd_valid)
    begin
        wb_alu <= cmd_alu;
        wb_br_en <= cmd_br_en;
        wb_u_imm <= cmd_u_imm;
        wb_rd <= cmd_rd;
        wb_byte_en <= byte_en;
    end
end

// no misaligned trap here, a halfword must stay inside one word
assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && ((is_half && cmd_alu[1:0] == 2'b11) || (is_word && cmd_alu[1:0] != 2'b00))
    |-> 1'b0)
    else $error("mem_stage: misaligned access at %h", cmd_alu);

endmodule : mem_stage

//--- write_back/write_back.sv
`timescale 1ns/10ps

module write_back
(
    input  logic                            wb_valid,
    input  rv32i_types::rv32i_word          wb_alu,
    input  logic                            wb_br_en,
    input  rv32i_types::rv32i_word          wb_pc_plus4,
    input  rv32i_types::rv32i_word          wb_u_imm,
    input  rv32i_types::reg_idx_t           wb_rd,
    input  logic                            wb_load_regfile,
    input  rv32i_ctrl::regfilemux_sel_t     wb_regfilemux_sel,
    input  rv32i_ctrl::pcmux_sel_t          wb_pcmux_sel,
    input  rv32i_types::byte_en_t           wb_byte_en,
    input  rv32i_types::rv32i_word          mem_rdata,

    // to regfile
    output logic                            load_regfile,
    output rv32i_types::reg_idx_t           rd,
    output rv32i_types::rv32i_word          rd_data,

    // to fetch
    output logic                            redirect_valid,
    output rv32i_types::rv32i_word          alu_out_to_pc,
    output rv32i_ctrl::pcmux_sel_t          pcmux_sel
);

logic [7:0]  load_byte;
logic [15:0] load_half;

assign load_regfile = wb_valid && wb_load_regfile;
assign rd = wb_rd;

assign redirect_valid = wb_valid && (wb_pcmux_sel != rv32i_ctrl::pcmux_pc_plus4);
assign alu_out_to_pc = wb_alu;
assign pcmux_sel = wb_pcmux_sel;

// pick the lane the memory stage enabled
always_comb
begin
    case (wb_byte_en)
        4'b0010: load_byte = mem_rdata[15:8];
        4'b0100: load_byte = mem_rdata[23:16];
        4'b1000: load_byte = mem_rdata[31:24];
        default: load_byte = mem_rdata[7:0];
    endcase
    case (wb_byte_en)
        4'b0110: load_half = mem_rdata[23:8];
        4'b1100: load_half = mem_rdata[31:16];
        default: load_half = mem_rdata[15:0];
    endcase
end

// regfile mux
always_comb
begin
    case (wb_regfilemux_sel)
        rv32i_ctrl::alu_out:  rd_data = wb_alu;
        rv32i_ctrl::br_en:    rd_data = {31'd0, wb_br_en};
        rv32i_ctrl::u_imm:    rd_data = wb_u_imm;
        rv32i_ctrl::lw:       rd_data = mem_rdata;
        rv32i_ctrl::pc_plus4: rd_data = wb_pc_plus4;
        rv32i_ctrl::lb:       rd_data = {{24{load_byte[7]}}, load_byte};
        rv32i_ctrl::lbu:      rd_data = {24'd0, load_byte};
        rv32i_ctrl::lh:       rd_data = {{16{load_half[15]}}, load_half};
        rv32i_ctrl::lhu:      rd_data = {16'd0, load_half};
        default:              rd_data = wb_alu;
    endcase
end

// enables come from mem_stage a cycle earlier, must match the load width
assert final (!(wb_valid && wb_regfilemux_sel inside {rv32i_ctrl::lb, rv32i_ctrl::lbu})
              || $onehot(wb_byte_en))
    else $error("write_back: byte load with enables %b", wb_byte_en);

assert final (!(wb_valid && wb_regfilemux_sel inside {rv32i_ctrl::lh, rv32i_ctrl::lhu})
              || (wb_byte_en inside {4'b0011, 4'b0110, 4'b1100}))
    else $error("write_back: halfword load with enables %b", wb_byte_en);

endmodule : write_back

//--- verilog/regfile.sv
`timescale 1ns/10ps

module regfile
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_regfile,
    input  rv32i_types::reg_idx_t   rd,
    input  rv32i_types::rv32i_word  rd_data,
    input  rv32i_types::reg_idx_t   rs1_addr,
    input  rv32i_types::reg_idx_t   rs2_addr,
    output rv32i_types::rv32i_word  rs1_data,
    output rv32i_types::rv32i_word  rs2_data
);

rv32i_types::rv32i_word regs [rv32i_types::REG_COUNT];

always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        for (int i = 0; i < rv32i_types::REG_COUNT; i++)
        begin
            regs[i] <= '0;
        end
    end
    else if (load_regfile && (rd != '0))      // x0 is never written
    begin
        regs[rd] <= rd_data;
    end
end

// no bypass, a write shows up after the edge
assign rs1_data = regs[rs1_addr];
assign rs2_data = regs[rs2_addr];

// whatever write_back sends, x0 reads zero on both ports
assert property (@(posedge clk) disable iff (!rst_n)
    ((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0)))
    else $error("regfile: x0 read nonzero");

endmodule : regfile

//--- verilog/wb_top.sv
`timescale 1ns/10ps

module wb_top
#(
    parameter int DATA_MEM_WORDS = 256
)
(
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            cmd_valid,
    input  rv32i_types::rv32i_word          cmd_alu,
    input  logic                            cmd_br_en,
    input  rv32i_types::rv32i_word          cmd_pc_plus4,
    input  rv32i_types::rv32i_word          cmd_u_imm,
    input  rv32i_types::rv32i_word          cmd_store_data,
    input  rv32i_types::reg_idx_t           cmd_rd,
    input  logic                            cmd_load_regfile,
    input  rv32i_ctrl::regfilemux_sel_t     cmd_regfilemux_sel,
    input  rv32i_ctrl::mem_op_t             cmd_mem_op,
    input  rv32i_ctrl::pcmux_sel_t          cmd_pcmux_sel,

    input  rv32i_types::reg_idx_t           rs1_addr,
    input  rv32i_types::reg_idx_t           rs2_addr,
    output rv32i_types::rv32i_word          rs1_data,
    output rv32i_types::rv32i_word          rs2_data,

    output logic                            redirect_valid,
    output rv32i_types::rv32i_word          alu_out_to_pc,
    output rv32i_ctrl::pcmux_sel_t          pcmux_sel
);

logic                           wb_valid;
rv32i_types::rv32i_word         wb_alu;
logic                           wb_br_en;
rv32i_types::rv32i_word         wb_pc_plus4;
rv32i_types::rv32i_word         wb_u_imm;
rv32i_types::reg_idx_t          wb_rd;
logic                           wb_load_regfile;
rv32i_ctrl::regfilemux_sel_t    wb_regfilemux_sel;
rv32i_ctrl::pcmux_sel_t         wb_pcmux_sel;
rv32i_types::byte_en_t          wb_byte_en;
rv32i_types::rv32i_word         mem_rdata;

logic                           load_regfile;
rv32i_types::reg_idx_t          rd;
rv32i_types::rv32i_word         rd_data;

mem_stage #(
    .DATA_MEM_WORDS (DATA_MEM_WORDS)
) u_mem_stage (
    .clk                (clk),
    .rst_n              (rst_n),
    .cmd_valid          (cmd_valid),
    .cmd_alu            (cmd_alu),
    .cmd_br_en          (cmd_br_en),
    .cmd_pc_plus4       (cmd_pc_plus4),
    .cmd_u_imm          (cmd_u_imm),
    .cmd_store_data     (cmd_store_data),
    .cmd_rd             (cmd_rd),
    .cmd_load_regfile   (cmd_load_regfile),
    .cmd_regfilemux_sel (cmd_regfilemux_sel),
    .cmd_mem_op         (cmd_mem_op),
    .cmd_pcmux_sel      (cmd_pcmux_sel),
    .wb_valid           (wb_valid),
    .wb_alu             (wb_alu),
    .wb_br_en           (wb_br_en),
    .wb_pc_plus4        (wb_pc_plus4),
    .wb_u_imm           (wb_u_imm),
    .wb_rd              (wb_rd),
    .wb_load_regfile    (wb_load_regfile),
    .wb_regfilemux_sel  (wb_regfilemux_sel),
    .wb_pcmux_sel       (wb_pcmux_sel),
    .wb_byte_en         (wb_byte_en),
    .mem_rdata          (mem_rdata)
);

write_back u_write_back (
    .wb_valid           (wb_valid),
    .wb_alu             (wb_alu),
    .wb_br_en           (wb_br_en),
    .wb_pc_plus4        (wb_pc_plus4),
    .wb_u_imm           (wb_u_imm),
    .wb_rd              (wb_rd),
    .wb_load_regfile    (wb_load_regfile),
    .wb_regfilemux_sel  (wb_regfilemux_sel),
    .wb_pcmux_sel       (wb_pcmux_sel),
    .wb_byte_en         (wb_byte_en),
    .mem_rdata          (mem_rdata),
    .load_regfile       (load_regfile),
    .rd                 (rd),
    .rd_data            (rd_data),
    .redirect_valid     (redirect_valid),
    .alu_out_to_pc      (alu_out_to_pc),
    .pcmux_sel          (pcmux_sel)
);

regfile u_regfile (
    .clk                (clk),
    .rst_n              (rst_n),
    .load_regfile       (load_regfile),
    .rd                 (rd),
    .rd_data            (rd_data),
    .rs1_addr           (rs1_addr),
    .rs2_addr           (rs2_addr),
    .rs1_data           (rs1_data),
    .rs2_data           (rs2_data)
);

endmodule : wb_top

//--- verif/tb_wb_vectors.svh
// add_row(mem_op, regfilemux_sel, pcmux_sel, load_regfile, rd, alu, br_en, pc_plus4, u_imm,
//         store_data, dont_care, check_reg (-1 none), expected)
// mem_op 0 none 1 lb 2 lh 3 lw 4 sb 5 sh 6 sw, regfilemux 0 alu 1 br 2 uimm 3 lw 4 pc4
// 5 lb 6 lbu 7 lh 8 lhu, pcmux 0 pc4 1 alu 2 alu_mod2
// dont_care bits 0 alu 1 br_en 2 pc_plus4 3 u_imm 4 store_data

// non-memory selects
add_row(0, 0, 0, 1, 1, 'h12345678, 0, 0, 0, 0, 'h1e, 1, 'h12345678);
add_row(0, 1, 0, 1, 2, 0, 1, 0, 0, 0, 'h1d, 2, 'h00000001);
add_row(0, 2, 0, 1, 3, 0, 0, 0, 'habcde000, 0, 'h17, 3, 'habcde000);
add_row(0, 4, 1, 1, 4, 'h200, 0, 'h104, 0, 0, 'h1a, 4, 'h00000104);
// word store then load on the next cycle
add_row(6, 0, 0, 0, 0, 'h40, 0, 0, 0, 'hdeadbeef, 'he, -1, 0);
add_row(3, 3, 0, 1, 5, 'h40, 0, 0, 0, 0, 'h1e, 5, 'hdeadbeef);
// byte stores into one word, upper data bits are junk
add_row(4, 0, 0, 0, 0, 'h80, 0, 0, 0, 'ha5a5a581, 'he, -1, 0);
add_row(4, 0, 0, 0, 0, 'h81, 0, 0, 0, 'h3c3c3c7f, 'he, -1, 0);
add_row(4, 0, 0, 0, 0, 'h82, 0, 0, 0, 'hffffffc3, 'he, -1, 0);
add_row(4, 0, 0, 0, 0, 'h83, 0, 0, 0, 'h00000024, 'he, -1, 0);
add_row(1, 5, 0, 1, 6, 'h80, 0, 0, 0, 0, 'h1e, 6, 'hffffff81);
add_row(1, 6, 0, 1, 7, 'h80, 0, 0, 0, 0, 'h1e, 7, 'h00000081);
add_row(1, 5, 0, 1, 6, 'h81, 0, 0, 0, 0, 'h1e, 6, 'h0000007f);
add_row(1, 6, 0, 1, 7, 'h82, 0, 0, 0, 0, 'h1e, 7, 'h000000c3);
add_row(1, 5, 0, 1, 8, 'h82, 0, 0, 0, 0, 'h1e, 8, 'hffffffc3);
add_row(1, 6, 0, 1, 9, 'h83, 0, 0, 0, 0, 'h1e, 9, 'h00000024);
add_row(1, 5, 0, 1, 10, 'h83, 0, 0, 0, 0, 'h1e, 10, 'h00000024);
add_row(1, 6, 0, 1, 11, 'h81, 0, 0, 0, 0, 'h1e, 11, 'h0000007f);
add_row(3, 3, 0, 1, 12, 'h80, 0, 0, 0, 0, 'h1e, 12, 'h24c37f81);
// halfwords, the word at 0xc0 becomes 7abc8001
add_row(5, 0, 0, 0, 0, 'hc0, 0, 0, 0, 'hffff8001, 'he, -1, 0);
add_row(5, 0, 0, 0, 0, 'hc2, 0, 0, 0, 'h12347abc, 'he, -1, 0);
add_row(2, 7, 0, 1, 13, 'hc0, 0, 0, 0, 0, 'h1e, 13, 'hffff8001);
add_row(2, 8, 0, 1, 14, 'hc0, 0, 0, 0, 0, 'h1e, 14, 'h00008001);
add_row(2, 7, 0, 1, 15, 'hc1, 0, 0, 0, 0, 'h1e, 15, 'hffffbc80);
add_row(2, 8, 0, 1, 16, 'hc1, 0, 0, 0, 0, 'h1e, 16, 'h0000bc80);
add_row(2, 7, 0, 1, 17, 'hc2, 0, 0, 0, 0, 'h1e, 17, 'h00007abc);
add_row(2, 8, 0, 1, 18, 'hc2, 0, 0, 0, 0, 'h1e, 18, 'h00007abc);
// x0 stays zero, load_regfile low keeps x1
add_row(0, 0, 0, 1, 0, 'hffffffff, 0, 0, 0, 0, 'h1e, 0, 'h00000000);
add_row(0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 'h1f, 1, 'h12345678);
// redirects
add_row(0, 0, 2, 1, 19, 'h301, 0, 0, 0, 0, 'h1e, 19, 'h00000301);
add_row(0, 0, 1, 0, 0, 'h400, 0, 0, 0, 0, 'h1e, -1, 0);
add_row(0, 4, 0, 1, 20, 0, 0, 'h88, 0, 0, 'h1b, 20, 'h00000088);

//--- verif/tb_wb_top.sv
`timescale 1ns/10ps

module tb_wb_top;

localparam int MAX_ROWS = 48;
localparam int DRIVE_DELAY = 2;                   // ns after the rising edge

logic                           clk;
logic                           rst_n;
logic                           cmd_valid;
rv32i_types::rv32i_word         cmd_alu;
logic                           cmd_br_en;
rv32i_types::rv32i_word         cmd_pc_plus4;
rv32i_types::rv32i_word         cmd_u_imm;
rv32i_types::rv32i_word         cmd_store_data;
rv32i_types::reg_idx_t          cmd_rd;
logic                           cmd_load_regfile;
rv32i_ctrl::regfilemux_sel_t    cmd_regfilemux_sel;
rv32i_ctrl::mem_op_t            cmd_mem_op;
rv32i_ctrl::pcmux_sel_t         cmd_pcmux_sel;
rv32i_types::reg_idx_t          rs1_addr;
rv32i_types::reg_idx_t          rs2_addr;
rv32i_types::rv32i_word         rs1_data;
rv32i_types::rv32i_word         rs2_data;
logic                           redirect_valid;
rv32i_types::rv32i_word         alu_out_to_pc;
rv32i_ctrl::pcmux_sel_t         pcmux_sel;

// stimulus table, one command per row
int                             row_op [MAX_ROWS];
int                             row_sel [MAX_ROWS];
int                             row_pc [MAX_ROWS];
int                             row_ld [MAX_ROWS];
int                             row_rd [MAX_ROWS];
int                             row_dc [MAX_ROWS];
int                             row_chk [MAX_ROWS];    // register to read back, -1 for none
rv32i_types::rv32i_word         row_alu [MAX_ROWS];
logic                           row_br [MAX_ROWS];
rv32i_types::rv32i_word         row_pc4 [MAX_ROWS];
rv32i_types::rv32i_word         row_uimm [MAX_ROWS];
rv32i_types::rv32i_word         row_sd [MAX_ROWS];
rv32i_types::rv32i_word         row_exp [MAX_ROWS];
int                             n_rows;
int                             errors;
int                             timeouts;

wb_top #(
    .DATA_MEM_WORDS (64)
) uut (
    .clk                (clk),
    .rst_n              (rst_n),
    .cmd_valid          (cmd_valid),
    .cmd_alu            (cmd_alu),
    .cmd_br_en          (cmd_br_en),
    .cmd_pc_plus4       (cmd_pc_plus4),
    .cmd_u_imm          (cmd_u_imm),
    .cmd_store_data     (cmd_store_data),
    .cmd_rd             (cmd_rd),
    .cmd_load_regfile   (cmd_load_regfile),
    .cmd_regfilemux_sel (cmd_regfilemux_sel),
    .cmd_mem_op         (cmd_mem_op),
    .cmd_pcmux_sel      (cmd_pcmux_sel),
    .rs1_addr           (rs1_addr),
    .rs2_addr           (rs2_addr),
    .rs1_data           (rs1_data),
    .rs2_data           (rs2_data),
    .redirect_valid     (redirect_valid),
    .alu_out_to_pc      (alu_out_to_pc),
    .pcmux_sel          (pcmux_sel)
);

always #20 clk = ~clk;

task automatic add_row(input int op, input int sel, input int pcs, input int ld, input int rd,
                       input rv32i_types::rv32i_word alu, input logic br,
                       input rv32i_types::rv32i_word pc4, input rv32i_types::rv32i_word uimm,
                       input rv32i_types::rv32i_word sd, input int dc, input int chk,
                       input rv32i_types::rv32i_word exp);
    row_op[n_rows] = op;
    row_sel[n_rows] = sel;
    row_pc[n_rows] = pcs;
    row_ld[n_rows] = ld;
    row_rd[n_rows] = rd;
    row_alu[n_rows] = alu;
    row_br[n_rows] = br;
    row_pc4[n_rows] = pc4;
    row_uimm[n_rows] = uimm;
    row_sd[n_rows] = sd;
    row_dc[n_rows] = dc;
    row_chk[n_rows] = chk;
    row_exp[n_rows] = exp;
    n_rows++;
endtask

task automatic build_table;
`include "tb_wb_vectors.svh"
endtask

// don't-care fields get random values, kept in the row for later checks
task automatic drive_row(input int i);
    if (row_dc[i][0]) row_alu[i] = $urandom;
    if (row_dc[i][1]) row_br[i] = $urandom % 2;
    if (row_dc[i][2]) row_pc4[i] = $urandom;
    if (row_dc[i][3]) row_uimm[i] = $urandom;
    if (row_dc[i][4]) row_sd[i] = $urandom;
    cmd_valid = 1'b1;
    cmd_alu = row_alu[i];
    cmd_br_en = row_br[i];
    cmd_pc_plus4 = row_pc4[i];
    cmd_u_imm = row_uimm[i];
    cmd_store_data = row_sd[i];
    cmd_rd = rv32i_types::reg_idx_t'(row_rd[i]);
    cmd_load_regfile = (row_ld[i] != 0);
    cmd_regfilemux_sel = rv32i_ctrl::regfilemux_sel_t'(row_sel[i]);
    cmd_mem_op = rv32i_ctrl::mem_op_t'(row_op[i]);
    cmd_pcmux_sel = rv32i_ctrl::pcmux_sel_t'(row_pc[i]);
endtask

task automatic check_redirect(input logic busy, input int exp_sel,
                              input rv32i_types::rv32i_word exp_pc);
    logic exp_valid;
    exp_valid = busy && (exp_sel != 0);               // anything but sequential redirects
    assert (redirect_valid === exp_valid)
    else
    begin
        $display("FAIL t=%0t redirect_valid: got %b expected %b", $time, redirect_valid,
                 exp_valid);
        errors++;
    end
    if (busy)
    begin
        assert (pcmux_sel === rv32i_ctrl::pcmux_sel_t'(exp_sel))
        else
        begin
            $display("FAIL t=%0t pcmux_sel: got %0d expected %0d", $time, pcmux_sel,
                     exp_sel);
            errors++;
        end
    end
    if (exp_valid)
    begin
        assert (alu_out_to_pc === exp_pc)
        else
        begin
            $display("FAIL t=%0t alu_out_to_pc: got %h expected %h", $time, alu_out_to_pc,
                     exp_pc);
            errors++;
        end
    end
endtask

task automatic check_regfile(input int i);
    rs1_addr = rv32i_types::reg_idx_t'(row_chk[i]);
    rs2_addr = rv32i_types::reg_idx_t'(row_chk[i]);
    #1;                                           // combinational read settles
    assert (rs1_data === row_exp[i])
    else
    begin
        $display("FAIL t=%0t rs1_data x%0d: got %h expected %h", $time, row_chk[i], rs1_data,
                 row_exp[i]);
        errors++;
    end
    assert (rs2_data === row_exp[i])
    else
    begin
        $display("FAIL t=%0t rs2_data x%0d: got %h expected %h", $time, row_chk[i], rs2_data,
                 row_exp[i]);
        errors++;
    end
endtask

initial
begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #DRIVE_DELAY rst_n = 1'b1;
end

initial
begin
    int cycle;
    int i;
    int checked;
    void'($urandom(32'h38bc4a03));
    clk = 1'b0;
    cmd_valid = 1'b0;
    cmd_alu = '0;
    cmd_br_en = 1'b0;
    cmd_pc_plus4 = '0;
    cmd_u_imm = '0;
    cmd_store_data = '0;
    cmd_rd = '0;
    cmd_load_regfile = 1'b0;
    cmd_regfilemux_sel = rv32i_ctrl::alu_out;
    cmd_mem_op = rv32i_ctrl::mem_none;
    cmd_pcmux_sel = rv32i_ctrl::pcmux_pc_plus4;
    rs1_addr = '0;
    rs2_addr = '0;
    errors = 0;
    timeouts = 0;
    n_rows = 0;
    build_table();

    cycle = 0;
    while (rst_n !== 1'b1 && cycle < 20)
    begin
        @(posedge clk);
        cycle++;
    end
    if (rst_n !== 1'b1)
    begin
        $display("timeout: the wait for reset release timed out");
        timeouts++;
    end
    else
    begin
        // row i is issued, row i-1 sits in MEM/WB, row i-2 has retired
        i = 0;
        checked = 0;
        while (checked < n_rows && i < n_rows + 8)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (i < n_rows)
                drive_row(i);
            else
                cmd_valid = 1'b0;
            if (i >= 1 && i - 1 < n_rows)
                check_redirect(1'b1, row_pc[i-1], row_alu[i-1]);
            else
                check_redirect(1'b0, 0, '0);   // reset or idle
            if (i >= 2)
            begin
                if (row_chk[i-2] >= 0)
                    check_regfile(i - 2);
                checked++;
            end
            i++;
        end
        if (checked < n_rows)
        begin
            $display("timeout: the wait for the end of the table timed out");
            timeouts++;
        end
    end

    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
        $display("Simulation completed successfully");
    else
        $display("Simulation failed");
    $finish;
end

endmodule : tb_wb_top

//--- src.f
+incdir+verif
common/rv32i_types.sv
common/rv32i_ctrl.sv
mem_stage/data_mem.sv
mem_stage/mem_stage.sv
write_back/write_back.sv
verilog/regfile.sv
verilog/wb_top.sv
verif/tb_wb_top.sv

//--- Bender.yml
package:
  name: rv32i_wb_backend

sources:
  - common/rv32i_types.sv
  - common/rv32i_ctrl.sv
  - mem_stage/data_mem.sv
  - mem_stage/mem_stage.sv
  - write_back/write_back.sv
  - verilog/regfile.sv
  - verilog/wb_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_wb_top.sv
